// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_dsp_core
FILELIST  ?= project.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@if grep -q ">>> FAIL" $(LOG); then echo "Simulation reported failure"; exit 1; fi
	@if ! grep -q ">>> PASS" $(LOG); then echo "Simulation did not complete"; exit 1; fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: hdl/dsp_core_top.sv
// Single clock core with no clock enable, where APB, memory and sequencer all run on clk
`timescale 1ns/1ps

module dsp_core_top (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       psel,
    input  logic                       penable,
    input  logic                       pwrite,
    input  logic [11:0]                paddr,
    input  logic [dsp_pkg::data_w-1:0] pwdata,
    output logic [dsp_pkg::data_w-1:0] prdata,
    output logic                       pready,
    output logic                       pslverr
);
    import dsp_pkg::*;

    // Host side
    logic                   wr_en;
    logic [addr_w-1:0]      wr_addr;
    logic [data_w-1:0]      wr_data;
    logic                   start;
    logic [reg_idx_w-1:0]   reg_idx;
    logic [data_w-1:0]      rd_data;

    // Fetch and decode
    logic [addr_w-1:0]      fetch_addr;
    logic [data_w-1:0]      rom_dout;
    logic                   busy;
    logic [addr_w-1:0]      pc;
    logic                   goto_ja;
    logic [addr_w-1:0]      i_field;
    logic                   double;
    logic                   fault;

    // Register file strobes
    logic                   short_load;
    logic                   long_load;
    logic                   pmod_en;
    logic [1:0]             mod_sel;
    logic [reg_idx_w-1:0]   r_field;
    logic [short_imm_w-1:0] short_imm;

    prog_apb_port prog_apb_port_inst (.*);

    prog_ram prog_ram_inst (.*);

    dsp_ctrl dsp_ctrl_inst (.*);

    pc_unit pc_unit_inst (.*);

    // Second word of a long load is taken straight off the memory output
    yaau_regs yaau_regs_inst (
        .long_imm (rom_dout),
        .*
    );

endmodule

// File: hdl/dsp_ctrl.sv
// Only goto, short, long and pointer-modify words are legal and any other T ends the run
`timescale 1ns/1ps

module dsp_ctrl (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          start,
    input  logic [dsp_pkg::data_w-1:0]    rom_dout,
    output logic                          goto_ja,
    output logic [dsp_pkg::addr_w-1:0]    i_field,
    output logic                          short_load,
    output logic                          long_load,
    output logic                          pmod_en,
    output logic [1:0]                    mod_sel,
    output logic [dsp_pkg::reg_idx_w-1:0] r_field,
    output logic [dsp_pkg::short_imm_w-1:0] short_imm,
    output logic                          double,
    output logic                          fault
);
    import dsp_pkg::*;

    instr_u word;
    logic   armed;      // Start seen but first word not yet on rom_dout
    logic   active;     // rom_dout holds a word of the current run

    assign word = rom_dout;

    // Fields are captured every cycle and only used under a strobe
    always_ff @(posedge clk) begin
        i_field   <= word.jump_view.ja[addr_w-1:0];
        short_imm <= word.short_view.imm;
        mod_sel   <= rom_dout[1:0];
        if (word.short_view.t[4:1] == t_short[4:1]) begin
            r_field <= {1'b0, word.short_view.rsel} ^ reg_j;
        end else if (word.short_view.t == t_long) begin
            r_field <= {1'b0, rom_dout[5:4]};
        end else begin
            r_field <= {1'b0, rom_dout[3:2]};   // Pointer for modify
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            goto_ja    <= 1'b0;
            short_load <= 1'b0;
            long_load  <= 1'b0;
            pmod_en    <= 1'b0;
            double     <= 1'b0;
            fault      <= 1'b0;
            armed      <= 1'b0;
            active     <= 1'b0;
        end else begin
            // Every strobe drops after one cycle
            goto_ja    <= 1'b0;
            short_load <= 1'b0;
            long_load  <= 1'b0;
            pmod_en    <= 1'b0;
            double     <= 1'b0;
            armed      <= start;

            if (start) begin
                fault  <= 1'b0;
                active <= 1'b0;     // Counter restarts with the old word still in flight
            end else if (armed) begin
                active <= 1'b1;     // Word at address 0 arrives next cycle
            end else if (active && !double) begin
                if (word.jump_view.t == t_goto[4:1]) begin
                    goto_ja <= 1'b1;
                    double  <= 1'b1;    // Word behind the goto is dropped
                end else if (word.short_view.t[4:1] == t_short[4:1]) begin
                    short_load <= 1'b1;
                end else if (word.short_view.t == t_long) begin
                    long_load <= 1'b1;
                    double    <= 1'b1;  // Next word is the data
                end else if (word.short_view.t == t_pmod) begin
                    pmod_en <= 1'b1;
                end else begin
                    // Illegal T stops decoding until the next start
                    fault  <= 1'b1;
                    active <= 1'b0;
                end
            end
        end
    end

endmodule

// File: hdl/dsp_pkg.sv
// Long loads pick r0 to r3 from bits 5:4 and pointer modify reads pointer 3:2 and mode 1:0
package dsp_pkg;

    localparam int data_w      = 16;
    localparam int addr_w      = 8;
    localparam int reg_idx_w   = 3;
    localparam int short_imm_w = 9;

    // T field codes with the low bit ignored for goto and short loads
    localparam logic [4:0] t_goto  = 5'b00000;
    localparam logic [4:0] t_short = 5'b00010;
    localparam logic [4:0] t_long  = 5'b01010;
    localparam logic [4:0] t_pmod  = 5'b01111;

    // Register file indices above the pointers
    localparam logic [reg_idx_w-1:0] reg_j  = 3'd4;
    localparam logic [reg_idx_w-1:0] reg_k  = 3'd5;
    localparam logic [reg_idx_w-1:0] reg_rb = 3'd6;
    localparam logic [reg_idx_w-1:0] reg_re = 3'd7;

    // Pointer post-modify modes
    localparam logic [1:0] mod_none = 2'd0;
    localparam logic [1:0] mod_inc  = 2'd1;
    localparam logic [1:0] mod_dec  = 2'd2;
    localparam logic [1:0] mod_incj = 2'd3;

    // APB byte addresses
    localparam logic [11:0] apb_ctrl_addr = 12'h400;
    localparam logic [11:0] apb_stat_addr = 12'h404;
    localparam logic [11:0] apb_reg_base  = 12'h420;

    // One instruction word in its two layouts
    typedef union packed {
        struct packed {
            logic [3:0]  t;
            logic [11:0] ja;            // Absolute target
        } jump_view;
        struct packed {
            logic [4:0]             t;
            logic [1:0]             rsel;   // j, k, rb, re
            logic [short_imm_w-1:0] imm;
        } short_view;
    } instr_u;

endpackage

// File: hdl/pc_unit.sv
// The counter wraps at 255 and a run only ends on a decoder fault or a restart
`timescale 1ns/1ps

module pc_unit (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       start,
    input  logic                       goto_ja,
    input  logic [dsp_pkg::addr_w-1:0] i_field,
    input  logic                       double,
    input  logic                       fault,
    output logic [dsp_pkg::addr_w-1:0] fetch_addr,
    output logic                       busy,
    output logic [dsp_pkg::addr_w-1:0] pc
);
    logic running;

    // A goto strobe always sits in its own shadow slot, so redirect the fetch right away
    assign fetch_addr = (goto_ja && double) ? i_field : pc;
    assign busy       = running & ~fault;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            running <= 1'b0;
            pc      <= '0;
        end else if (start) begin
            running <= 1'b1;
            pc      <= '0;
        end else if (fault) begin
            running <= 1'b0;    // Counter freezes where the fault hit
        end else if (running) begin
            pc <= fetch_addr + 1'b1;
        end
    end

endmodule

// File: hdl/prog_apb_port.sv
// Zero wait state APB3 slave where program words are write-only and refused while busy
`timescale 1ns/1ps

module prog_apb_port (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          psel,
    input  logic                          penable,
    input  logic                          pwrite,
    input  logic [11:0]                   paddr,
    input  logic [dsp_pkg::data_w-1:0]    pwdata,
    output logic [dsp_pkg::data_w-1:0]    prdata,
    output logic                          pready,
    output logic                          pslverr,
    output logic                          wr_en,
    output logic [dsp_pkg::addr_w-1:0]    wr_addr,
    output logic [dsp_pkg::data_w-1:0]    wr_data,
    output logic                          start,
    input  logic                          busy,
    input  logic                          fault,
    input  logic [dsp_pkg::addr_w-1:0]    pc,
    output logic [dsp_pkg::reg_idx_w-1:0] reg_idx,
    input  logic [dsp_pkg::data_w-1:0]    rd_data
);
    import dsp_pkg::*;

    logic access;
    logic aligned;
    logic is_prog;
    logic is_ctrl;
    logic is_stat;
    logic is_reg;
    logic mapped;

    assign access  = psel & penable;
    assign aligned = (paddr[1:0] == 2'b00);

    // Address map
    assign is_prog = aligned && (paddr < apb_ctrl_addr);
    assign is_ctrl = (paddr == apb_ctrl_addr);
    assign is_stat = (paddr == apb_stat_addr);
    assign is_reg  = aligned &&
                     (paddr[11:reg_idx_w+2] == apb_reg_base[11:reg_idx_w+2]);
    assign mapped  = is_prog | is_ctrl | is_stat | is_reg;

    assign reg_idx = paddr[reg_idx_w+1:2];  // Word index inside the register window
    assign pready  = 1'b1;

    assign pslverr = access && (!mapped || (pwrite && is_prog && busy));

    // Read mux
    always_comb begin
        prdata = '0;
        if (is_stat) begin
            prdata = {pc, {(data_w-addr_w-2){1'b0}}, fault, busy};
        end else if (is_reg) begin
            prdata = rd_data;
        end
    end

    // Memory write and start go out one cycle after the access phase
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            wr_en <= 1'b0;
            start <= 1'b0;
        end else begin
            wr_en <= access & pwrite & is_prog & ~busy;
            start <= access & pwrite & is_ctrl & pwdata[0];
        end
    end

    always_ff @(posedge clk) begin
        wr_addr <= paddr[addr_w+1:2];
        wr_data <= pwdata;
    end

endmodule

// File: hdl/prog_ram.sv
// Reading the address being written in the same cycle returns the old word
`timescale 1ns/1ps

module prog_ram (
    input  logic                       clk,
    input  logic                       wr_en,
    input  logic [dsp_pkg::addr_w-1:0] wr_addr,
    input  logic [dsp_pkg::data_w-1:0] wr_data,
    input  logic [dsp_pkg::addr_w-1:0] fetch_addr,
    output logic [dsp_pkg::data_w-1:0] rom_dout
);
    import dsp_pkg::*;

    logic [data_w-1:0] mem [0:2**addr_w-1];

    // Host write port and fetch read port on the same clock
    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_addr] <= wr_data;
        end
        rom_dout <= mem[fetch_addr];    // One cycle fetch latency
    end

endmodule

// File: hdl/yaau_regs.sv
// All registers reset to zero and the r3 wrap applies on ++ and ++j only when re is non-zero
`timescale 1ns/1ps

module yaau_regs (
    input  logic                            clk,
    input  logic                            rst,
    input  logic                            short_load,
    input  logic                            long_load,
    input  logic                            pmod_en,
    input  logic [1:0]                      mod_sel,
    input  logic [dsp_pkg::reg_idx_w-1:0]   r_field,
    input  logic [dsp_pkg::short_imm_w-1:0] short_imm,
    input  logic [dsp_pkg::data_w-1:0]      long_imm,
    input  logic [dsp_pkg::reg_idx_w-1:0]   reg_idx,
    output logic [dsp_pkg::data_w-1:0]      rd_data
);
    import dsp_pkg::*;

    logic [data_w-1:0] regs [0:2**reg_idx_w-1];    // r0-r3 then j, k, rb, re
    logic [1:0]        ptr_idx;
    logic [data_w-1:0] ptr;
    logic [data_w-1:0] step;
    logic [data_w-1:0] ptr_next;
    logic              wrap;

    assign ptr_idx = r_field[1:0];
    assign ptr     = regs[{1'b0, ptr_idx}];

    always_comb begin
        case (mod_sel)
            mod_none: step = '0;
            mod_inc:  step = {{(data_w-1){1'b0}}, 1'b1};
            mod_dec:  step = '1;                // Minus one
            mod_incj: step = regs[reg_j];
            default:  step = '0;
        endcase
        // Circular buffer on r3 checked before the step
        wrap = (ptr_idx == 2'd3) &&
               ((mod_sel == mod_inc) || (mod_sel == mod_incj)) &&
               (ptr == regs[reg_re]) && (regs[reg_re] != '0);
        ptr_next = wrap ? regs[reg_rb] : ptr + step;
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < 2**reg_idx_w; i++) begin
                regs[i] <= '0;
            end
        end else if (short_load) begin
            regs[r_field] <= {{(data_w-short_imm_w){1'b0}}, short_imm};
        end else if (long_load) begin
            regs[r_field] <= long_imm;
        end else if (pmod_en) begin
            regs[{1'b0, ptr_idx}] <= ptr_next;
        end
    end

    assign rd_data = regs[reg_idx];     // Host reads at any time

endmodule

// File: project.f
hdl/dsp_pkg.sv
hdl/prog_apb_port.sv
hdl/prog_ram.sv
hdl/dsp_ctrl.sv
hdl/pc_unit.sv
hdl/yaau_regs.sv
hdl/dsp_core_top.sv
testbench/dsp_core_asserts.sv
testbench/dsp_checker.sv
testbench/tb_dsp_core.sv

// File: testbench/dsp_checker.sv
// Checks pready on every access and compares masked read data and pslverr while chk_en is high
`timescale 1ns/1ps

module dsp_checker (
    input  logic        clk,
    input  logic        psel,
    input  logic        penable,
    input  logic        pwrite,
    input  logic [11:0] paddr,
    input  logic [15:0] prdata,
    input  logic        pready,
    input  logic        pslverr,
    input  logic        chk_en,
    input  logic        chk_err,
    input  logic [15:0] chk_exp,
    input  logic [15:0] chk_mask,
    output int          error_count
);
    import dsp_pkg::*;

    // Readable name for an APB address
    function automatic string reg_name(input logic [11:0] a);
        string names [0:7];
        names = '{"r0", "r1", "r2", "r3", "j", "k", "rb", "re"};
        if (a == apb_stat_addr) begin
            return "status";
        end else if (a >= apb_reg_base && a < apb_reg_base + 12'd32) begin
            return names[(a - apb_reg_base) >> 2];
        end
        return $sformatf("prdata@0x%03h", a);
    endfunction

    initial error_count = 0;

    always @(posedge clk) begin
        if (psel && penable && pready !== 1'b1) begin
            $display("** Error: pready = 0x%0h, expected 0x1 at address 0x%03h",
                     pready, paddr);
            error_count++;
        end
        if (psel && penable && chk_en) begin
            if (pslverr !== chk_err) begin
                $display("** Error: pslverr = 0x%0h, expected 0x%0h at address 0x%03h",
                         pslverr, chk_err, paddr);
                error_count++;
            end else if (!pwrite && !chk_err &&
                         ((prdata & chk_mask) !== (chk_exp & chk_mask))) begin
                $display("** Error: %s = 0x%04h, expected 0x%04h (mask 0x%04h)",
                         reg_name(paddr), prdata, chk_exp, chk_mask);
                error_count++;
            end
        end
    end

endmodule

// File: testbench/dsp_core_asserts.sv
// Watches the decoder strobes and counter state through the nets of the top level
`timescale 1ns/1ps

module dsp_core_asserts (
    input logic clk,
    input logic rst,
    input logic goto_ja,
    input logic short_load,
    input logic long_load,
    input logic pmod_en,
    input logic double,
    input logic fault,
    input logic busy
);
    // One instruction per cycle
    a_one_strobe: assert property (@(posedge clk) disable iff (rst)
        $onehot0({goto_ja, short_load, long_load, pmod_en}))
        else $error("More than one decoder strobe in a cycle");

    // Shadow slot is never decoded
    a_double_slot: assert property (@(posedge clk) disable iff (rst)
        double |=> !(goto_ja || short_load || long_load || pmod_en))
        else $error("Decoder strobe in the slot after double");

    // A decoder fault only comes out of a running counter and ends it at once
    a_fault_idle: assert property (@(posedge clk) disable iff (rst)
        $rose(fault) |-> $past(busy) && !busy)
        else $error("Busy did not fall in the cycle fault rose");

endmodule

bind dsp_core_top dsp_core_asserts dsp_core_asserts_inst (
    .clk        (clk),
    .rst        (rst),
    .goto_ja    (goto_ja),
    .short_load (short_load),
    .long_load  (long_load),
    .pmod_en    (pmod_en),
    .double     (double),
    .fault      (fault),
    .busy       (busy)
);

// File: testbench/tb_dsp_core.sv
// Registers carry over between the six APB runs and the last run never ends
`timescale 1ns/1ps

module tb_dsp_core;
    import dsp_pkg::*;

    localparam logic [15:0] illegal_word = 16'hF800;
    localparam int          poll_limit   = 200;

    logic        clk;
    logic        rst;
    logic        psel;
    logic        penable;
    logic        pwrite;
    logic [11:0] paddr;
    logic [15:0] pwdata;
    logic [15:0] prdata;
    logic        pready;
    logic        pslverr;

    // Expected-value hand-off to the checker
    logic        chk_en;
    logic        chk_err;
    logic [15:0] chk_exp;
    logic [15:0] chk_mask;
    int          chk_errors;

    logic [data_w-1:0] prog [0:2**addr_w-1];
    int                prog_len;
    logic [data_w-1:0] exp_regs [0:2**reg_idx_w-1];
    logic              exp_fault;
    logic [addr_w-1:0] exp_pc;
    int                tb_errors;
    integer            seed;

    dsp_core_top dsp_core_top_inst (.*);

    dsp_checker dsp_checker_inst (
        .clk         (clk),
        .psel        (psel),
        .penable     (penable),
        .pwrite      (pwrite),
        .paddr       (paddr),
        .prdata      (prdata),
        .pready      (pready),
        .pslverr     (pslverr),
        .chk_en      (chk_en),
        .chk_err     (chk_err),
        .chk_exp     (chk_exp),
        .chk_mask    (chk_mask),
        .error_count (chk_errors)
    );

    always #5 clk = ~clk;

    // Instruction encoders
    function automatic logic [15:0] enc_goto(input logic [7:0] target);
        return {t_goto[4:1], 4'h0, target};
    endfunction

    function automatic logic [15:0] enc_short(input logic [1:0] rsel, input logic [8:0] imm);
        return {t_short, rsel, imm};
    endfunction

    function automatic logic [15:0] enc_long(input logic [1:0] r);
        return {t_long, 5'b0, r, 4'b0};
    endfunction

    function automatic logic [15:0] enc_pmod(input logic [1:0] p, input logic [1:0] m);
        return {t_pmod, 7'b0, p, m};
    endfunction

    function automatic void emit(input logic [15:0] w);
        prog[prog_len] = w;
        prog_len++;
    endfunction

    function automatic void clear_prog();
        for (int i = 0; i < 2**addr_w; i++) begin
            prog[i] = illegal_word;
        end
        prog_len = 0;
    endfunction

    // ISA model that walks the program from address 0 until an illegal word
    function automatic void run_reference();
        logic [7:0]  a;
        logic [15:0] w;
        logic [15:0] step;
        logic [1:0]  p;
        a = '0;
        exp_fault = 1'b0;
        for (int steps = 0; steps < 1000 && !exp_fault; steps++) begin
            w = prog[a];
            p = w[3:2];
            if (w[15:12] == t_goto[4:1]) begin
                a = w[7:0];
            end else if (w[15:12] == t_short[4:1]) begin
                exp_regs[{1'b1, w[10:9]}] = {7'b0, w[8:0]};
                a = a + 8'd1;
            end else if (w[15:11] == t_long) begin
                exp_regs[{1'b0, w[5:4]}] = prog[a + 8'd1];
                a = a + 8'd2;
            end else if (w[15:11] == t_pmod) begin
                case (w[1:0])
                    2'd0:    step = 16'h0000;
                    2'd1:    step = 16'h0001;
                    2'd2:    step = 16'hFFFF;
                    default: step = exp_regs[reg_j];
                endcase
                if (p == 2'd3 && w[0] && exp_regs[3] == exp_regs[reg_re] &&
                    exp_regs[reg_re] != 0)
                    exp_regs[3] = exp_regs[reg_rb];
                else
                    exp_regs[{1'b0, p}] = exp_regs[{1'b0, p}] + step;
                a = a + 8'd1;
            end else begin
                exp_fault = 1'b1;
                exp_pc = a + 8'd2;      // Fetch and decode stages ahead of the fault
            end
        end
    endfunction

    // APB transfers start 1 ns after a rising edge and end the same way
    task automatic apb_xfer(input logic wr, input logic [11:0] addr,
                            input logic [15:0] data, output logic [15:0] rdata);
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = wr;
        paddr   = addr;
        pwdata  = data;
        @(posedge clk);
        #1 penable = 1'b1;
        @(posedge clk);
        rdata = prdata;
        #1;
        psel    = 1'b0;
        penable = 1'b0;
        chk_en  = 1'b0;
        chk_err = 1'b0;
    endtask

    task automatic expect_read(input logic [11:0] addr, input logic [15:0] exp,
                               input logic [15:0] mask);
        logic [15:0] d;
        chk_en   = 1'b1;
        chk_exp  = exp;
        chk_mask = mask;
        apb_xfer(1'b0, addr, 16'h0, d);
    endtask

    task automatic expect_slverr(input logic wr, input logic [11:0] addr);
        logic [15:0] d;
        chk_en  = 1'b1;
        chk_err = 1'b1;
        apb_xfer(wr, addr, 16'h1234, d);
    endtask

    task automatic load_program();
        logic [15:0] d;
        for (int i = 0; i < prog_len; i++) begin
            apb_xfer(1'b1, 12'(i * 4), prog[i], d);
        end
    endtask

    task automatic run_and_wait();
        logic [15:0] d;
        bit          done;
        done = 0;
        apb_xfer(1'b1, apb_ctrl_addr, 16'h0001, d);
        for (int i = 0; i < poll_limit && !done; i++) begin
            apb_xfer(1'b0, apb_stat_addr, 16'h0, d);
            done = !d[0];
        end
        if (!done) begin
            $display("Timeout: busy still high after %0d status polls", poll_limit);
            tb_errors++;
        end
    endtask

    task automatic run_and_check();
        load_program();
        run_and_wait();
        run_reference();
        for (int i = 0; i < 8; i++) begin
            expect_read(apb_reg_base + 12'(i * 4), exp_regs[i], 16'hFFFF);
        end
        expect_read(apb_stat_addr, {exp_pc, 6'b0, exp_fault, 1'b0}, 16'hFFFF);
    endtask

    initial begin
        clk      = 0;
        rst      = 1;
        psel     = 0;
        penable  = 0;
        pwrite   = 0;
        paddr    = '0;
        pwdata   = '0;
        chk_en   = 0;
        chk_err  = 0;
        chk_exp  = '0;
        chk_mask = '0;
        tb_errors = 0;
        seed = 32'h9f5b12f8;
        for (int i = 0; i < 8; i++) exp_regs[i] = '0;
        repeat (3) @(posedge clk);
        #1 rst = 0;

        // Short loads into j, k, rb, re
        clear_prog();
        for (int i = 0; i < 4; i++) emit(enc_short(2'(i), 9'($random(seed))));
        emit(illegal_word);
        run_and_check();

        // Long loads with data words that look like random instructions
        clear_prog();
        for (int i = 0; i < 4; i++) begin
            emit(enc_long(2'(i)));
            emit(16'($random(seed)));
        end
        emit(illegal_word);
        run_and_check();

        // Pointer modify on r0 to r2
        clear_prog();
        emit(enc_short(2'd0, 9'($random(seed))));
        emit(enc_pmod(2'd0, mod_inc));
        emit(enc_pmod(2'd1, mod_dec));
        emit(enc_pmod(2'd2, mod_incj));
        emit(enc_pmod(2'd0, mod_none));
        emit(enc_pmod(2'd1, mod_incj));
        emit(enc_pmod(2'd2, mod_dec));
        emit(enc_pmod(2'd0, mod_dec));
        emit(illegal_word);
        run_and_check();

        // Circular r3 and then re at zero
        clear_prog();
        emit(enc_short(2'd2, 9'd5));
        emit(enc_short(2'd3, 9'd8));
        emit(enc_long(2'd3));
        emit(16'd7);
        emit(enc_pmod(2'd3, mod_inc));
        emit(enc_pmod(2'd3, mod_inc));      // Equal to re so wraps to rb
        emit(enc_pmod(2'd3, mod_incj));
        emit(enc_short(2'd3, 9'd0));
        emit(enc_long(2'd3));
        emit(16'hFFFF);
        emit(enc_pmod(2'd3, mod_inc));
        emit(enc_pmod(2'd3, mod_inc));
        emit(illegal_word);
        run_and_check();

        // Goto over a block of loads
        clear_prog();
        emit(enc_goto(8'd4));
        emit(enc_short(2'd0, 9'h1AA));
        emit(enc_short(2'd1, 9'h155));
        emit(enc_short(2'd2, 9'h0CC));
        emit(enc_short(2'd3, 9'h0F0));
        emit(illegal_word);
        run_and_check();

        // Endless loop keeps busy high for the APB error cases
        clear_prog();
        emit(enc_goto(8'd0));
        load_program();
        begin
            logic [15:0] d;
            apb_xfer(1'b1, apb_ctrl_addr, 16'h0001, d);
        end
        expect_read(apb_stat_addr, 16'h0001, 16'h0003);   // Restart cleared fault
        expect_slverr(1'b1, 12'h010);
        expect_slverr(1'b0, 12'h408);
        repeat (2) @(posedge clk);

        $display("Errors: checker %0d, testbench %0d", chk_errors, tb_errors);
        if (chk_errors == 0 && tb_errors == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule
